// File: tb/program_input.txt
# columns: tag, then hex fields; I word | D addr value | W reg value | S addr value
# I lines fill imem from address 0, W and S lines are the in-order traces
I 2840000c  # 0  addi r1, r0, 12
I 28820007  # 1  addi r2, r1, 7
I 00c22000  # 2  add r3, r1, r2
I 01061004  # 3  sub r4, r3, r1
I 0148100c  # 4  or r5, r4, r1
I 018a4008  # 5  and r6, r5, r4
I 01cc0210  # 6  sll r7, r6, 4
I 2a01ffc0  # 7  addi r8, r0, -64
I 02500114  # 8  sra r9, r8, 2
I 02927004  # 9  sub r10, r9, r7
I 00022000  # 10 add r0, r1, r2
I 02c01000  # 11 add r11, r0, r1
I 2b000040  # 12 addi r12, r0, 0x40
I 43580000  # 13 lw r13, 0(r12)
I 039a1000  # 14 add r14, r13, r1
I 43d80001  # 15 lw r15, 1(r12)
I 2c1c0020  # 16 addi r16, r14, 0x20
I 3c180002  # 17 sw r16, 2(r12)
I 44580002  # 18 lw r17, 2(r12)
I 3c580003  # 19 sw r17, 3(r12)
I 10440001  # 20 bne r1, r2, +1
I 2d0007ff  # 21 addi r20, r0, 0x7ff
I 33c00001  # 22 blt r15, r0, +1
I 2d0007fe  # 23 addi r20, r0, 0x7fe
I 2c83fff4  # 24 addi r18, r1, -12
I 14800001  # 25 bne r18, r0, +1
I 2cc00003  # 26 addi r19, r0, 3
I 34c20001  # 27 blt r19, r1, +1
I 2d000001  # 28 addi r20, r0, 1
I 30660001  # 29 blt r1, r19, +1
I 2d000055  # 30 addi r20, r0, 0x55
I 18000023  # 31 jal 35
I 2daa0001  # 32 addi r22, r21, 1
I 08000026  # 33 j 38
I 2d000066  # 34 addi r20, r0, 0x66
I 2d400099  # 35 addi r21, r0, 0x99
I 27c00000  # 36 jr r31
I 2d000077  # 37 addi r20, r0, 0x77
I 3fd80004  # 38 sw r31, 4(r12)
I 08000027  # 39 j 39
D 40 00000100
D 41 fffffffd
W 01 0000000c
W 02 00000013
W 03 0000001f
W 04 00000013
W 05 0000001f
W 06 00000013
W 07 00000130
W 08 ffffffc0
W 09 fffffff0
W 0a fffffec0
W 0b 0000000c
W 0c 00000040
W 0d 00000100
W 0e 0000010c
W 0f fffffffd
W 10 0000012c
W 11 0000012c
W 12 00000000
W 13 00000003
W 14 00000055
W 1f 00000020
W 15 00000099
W 16 0000009a
S 42 0000012c
S 43 0000012c
S 44 00000020

// File: vlog.f
logic/proc_pkg.sv
logic/alu.sv
logic/fetch_stage.sv
logic/decode_stage.sv
logic/hazard_unit.sv
logic/execute_stage.sv
logic/mem_wb_stage.sv
logic/processor.sv
tb/tb_env_model.sv
tb/tb_processor.sv

// File: Bender.yml
package:
  name: dlx_pipeline

sources:
  - logic/proc_pkg.sv
  - logic/alu.sv
  - logic/fetch_stage.sv
  - logic/decode_stage.sv
  - logic/hazard_unit.sv
  - logic/execute_stage.sv
  - logic/mem_wb_stage.sv
  - logic/processor.sv
  - target: simulation
    files:
      - tb/tb_env_model.sv
      - tb/tb_processor.sv

// File: tb/tb_processor.sv
// ======================================================================
// program-driven testbench, checks register-write and store traces in order
// program, data and traces come from tb/program_input.txt
// the last I word must be a jump to itself, it marks the end of the program
// ======================================================================
`timescale 1ns/1ps

module tb_processor;

    logic        clock = 1'b0;
    logic        rst_n = 1'b0;
    logic [31:0] address_imem;
    logic [31:0] q_imem;
    logic [31:0] address_dmem;
    logic [31:0] data;
    logic        wren;
    logic [31:0] q_dmem;
    logic        ctrl_write_enable;
    logic [4:0]  ctrl_write_reg;
    logic [4:0]  ctrl_read_reg_a;
    logic [4:0]  ctrl_read_reg_b;
    logic [31:0] data_write_reg;
    logic [31:0] data_read_reg_a;
    logic [31:0] data_read_reg_b;

    logic [4:0]  exp_w_reg [$];  // expected register writes, in order
    logic [31:0] exp_w_val [$];
    logic [31:0] exp_s_addr [$]; // expected stores, in order
    logic [31:0] exp_s_val [$];
    int          insn_count = 0;
    logic        loaded = 1'b0;
    logic        halt_seen;
    int          drain;

    always #4 clock = ~clock; // 8 ns period

    processor #(
        .reset_pc (32'd0)
    ) processor_i (
        .clock             (clock),
        .rst_n             (rst_n),
        .address_imem      (address_imem),
        .q_imem            (q_imem),
        .address_dmem      (address_dmem),
        .data              (data),
        .wren              (wren),
        .q_dmem            (q_dmem),
        .ctrl_write_enable (ctrl_write_enable),
        .ctrl_write_reg    (ctrl_write_reg),
        .ctrl_read_reg_a   (ctrl_read_reg_a),
        .ctrl_read_reg_b   (ctrl_read_reg_b),
        .data_write_reg    (data_write_reg),
        .data_read_reg_a   (data_read_reg_a),
        .data_read_reg_b   (data_read_reg_b)
    );

    tb_env_model env_i (
        .clock             (clock),
        .address_imem      (address_imem),
        .q_imem            (q_imem),
        .address_dmem      (address_dmem),
        .data              (data),
        .wren              (wren),
        .q_dmem            (q_dmem),
        .ctrl_write_enable (ctrl_write_enable),
        .ctrl_write_reg    (ctrl_write_reg),
        .ctrl_read_reg_a   (ctrl_read_reg_a),
        .ctrl_read_reg_b   (ctrl_read_reg_b),
        .data_write_reg    (data_write_reg),
        .data_read_reg_a   (data_read_reg_a),
        .data_read_reg_b   (data_read_reg_b)
    );

    task automatic stop_on_failure();
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] expected,
                                   input logic [31:0] actual);
        $display("[FAIL] %s expected 0x%08h actual 0x%08h", name, expected, actual);
        stop_on_failure();
    endtask

    task automatic report_problem(input string why);
        $display("ERROR: %s", why);
        stop_on_failure();
    endtask

    // tag char, then one or two hex fields, '#' comments to end of line
    task automatic load_program();
        int          fd;
        int          c;
        int          n;
        logic [31:0] a;
        logic [31:0] b;
        fd = $fopen("tb/program_input.txt", "r");
        if (fd == 0) begin
            report_problem("cannot open tb/program_input.txt");
        end else begin
            env_i.clear_all();
            c = $fgetc(fd);
            while (c != -1) begin
                if (c == "#") begin
                    while (c != -1 && c != "\n")
                        c = $fgetc(fd);
                end else if (c == "I") begin
                    n = $fscanf(fd, "%h", a);
                    env_i.put_insn(insn_count, a); // imem from address 0 up
                    insn_count++;
                end else if (c == "D" || c == "W" || c == "S") begin
                    n = $fscanf(fd, "%h %h", a, b);
                    if (n != 2)
                        report_problem("data file line with a missing field");
                    if (c == "D") begin
                        env_i.put_data(a, b);
                    end else if (c == "W") begin
                        exp_w_reg.push_back(a[4:0]);
                        exp_w_val.push_back(b);
                    end else begin
                        exp_s_addr.push_back(a);
                        exp_s_val.push_back(b);
                    end
                end
                if (c != -1)
                    c = $fgetc(fd);
            end
            $fclose(fd);
        end
    endtask

    // nothing may retire or store while the pipe holds only nops
    task automatic check_idle();
        assert (address_imem == 32'd0)
            else report_mismatch("address_imem", 32'd0, address_imem);
        assert (wren == 1'b0)
            else report_mismatch("wren", 32'd0, {31'd0, wren});
        assert (ctrl_write_enable == 1'b0)
            else report_mismatch("ctrl_write_enable", 32'd0, {31'd0, ctrl_write_enable});
    endtask

    task automatic check_retirement();
        logic [4:0]  w_reg;
        logic [31:0] w_val;
        logic [31:0] s_addr;
        logic [31:0] s_val;
        if (ctrl_write_enable) begin
            assert (ctrl_write_reg != 5'd0)
                else report_problem("register write enabled for r0");
            assert (exp_w_reg.size() != 0)
                else report_problem("register write with no write left in the trace");
            w_reg = exp_w_reg.pop_front();
            w_val = exp_w_val.pop_front();
            assert (ctrl_write_reg == w_reg)
                else report_mismatch("ctrl_write_reg", {27'd0, w_reg}, {27'd0, ctrl_write_reg});
            assert (data_write_reg == w_val)
                else report_mismatch("data_write_reg", w_val, data_write_reg);
        end
        if (wren) begin
            assert (exp_s_addr.size() != 0)
                else report_problem("store with no store left in the trace");
            s_addr = exp_s_addr.pop_front();
            s_val  = exp_s_val.pop_front();
            assert (address_dmem == s_addr)
                else report_mismatch("address_dmem", s_addr, address_dmem);
            assert (data == s_val)
                else report_mismatch("data", s_val, data);
        end
    endtask

    initial begin
        load_program();
        loaded = 1'b1;
        repeat (8) begin
            @(posedge clock);
            check_idle();              // pc held at reset_pc
        end
        @(negedge clock);
        rst_n = 1'b1;
        @(posedge clock);
        check_idle();                  // first cycle out of reset
        halt_seen = 1'b0;
        drain     = 0;
        while (drain < 12) begin       // let the pipe empty behind the self-jump
            @(posedge clock);
            check_retirement();
            if (address_imem == insn_count - 1)
                halt_seen = 1'b1;
            if (halt_seen)
                drain++;
        end
        if (exp_w_reg.size() == 0 && exp_s_addr.size() == 0) begin
            $display("RESULT: PASS");
            $finish;
        end else begin
            $display("ERROR: program halted with %0d writes and %0d stores still expected",
                     exp_w_reg.size(), exp_s_addr.size());
            stop_on_failure();
        end
    end

    // budget scales with program length
    initial begin
        wait (loaded);
        repeat (20 * insn_count + 100) @(posedge clock);
        $display("ERROR: timed out after %0d cycles without finishing the program",
                 20 * insn_count + 100);
        stop_on_failure();
    end

endmodule

// File: tb/tb_env_model.sv
// ======================================================================
// behavioral imem, dmem and register file for the core ports
// 256 words each, word addressed by the low 8 bits, reads combinational
// regfile writes on posedge and returns the write data on a same-cycle read
// ======================================================================
`timescale 1ns/1ps

module tb_env_model (
    input  logic        clock,
    input  logic [31:0] address_imem,
    output logic [31:0] q_imem,
    input  logic [31:0] address_dmem,
    input  logic [31:0] data,
    input  logic        wren,
    output logic [31:0] q_dmem,
    input  logic        ctrl_write_enable,
    input  logic [4:0]  ctrl_write_reg,
    input  logic [4:0]  ctrl_read_reg_a,
    input  logic [4:0]  ctrl_read_reg_b,
    input  logic [31:0] data_write_reg,
    output logic [31:0] data_read_reg_a,
    output logic [31:0] data_read_reg_b
);

    logic [31:0] imem [0:255];
    logic [31:0] dmem [0:255];
    logic [31:0] regs [0:31];

    // stray imem words decode as r0 writes, so wrong-path fetches stay harmless
    task automatic clear_all();
        for (int i = 0; i < 256; i++) begin
            imem[i] = {24'd0, i[7:0]};
            dmem[i] = {24'hd0e0f0, i[7:0]}; // recognizable, per address
        end
        for (int i = 0; i < 32; i++)
            regs[i] = 32'd0;
    endtask

    task automatic put_insn(input logic [31:0] addr, input logic [31:0] word);
        imem[addr[7:0]] = word;
    endtask

    task automatic put_data(input logic [31:0] addr, input logic [31:0] word);
        dmem[addr[7:0]] = word;
    endtask

    assign q_imem = imem[address_imem[7:0]];
    assign q_dmem = dmem[address_dmem[7:0]];

    always @(posedge clock) begin
        if (wren)
            dmem[address_dmem[7:0]] <= data;
        if (ctrl_write_enable && ctrl_write_reg != 5'd0)
            regs[ctrl_write_reg] <= data_write_reg; // r0 hardwired
    end

    // write-through so decode sees the value retiring this cycle
    assign data_read_reg_a = (ctrl_read_reg_a == 5'd0) ? 32'd0 :
        (ctrl_write_enable && ctrl_write_reg == ctrl_read_reg_a) ? data_write_reg :
        regs[ctrl_read_reg_a];
    assign data_read_reg_b = (ctrl_read_reg_b == 5'd0) ? 32'd0 :
        (ctrl_write_enable && ctrl_write_reg == ctrl_read_reg_b) ? data_write_reg :
        regs[ctrl_read_reg_b];

endmodule

// File: logic/processor.sv
// ======================================================================
// 5-stage pipelined core, memories and register file are external
// imem/dmem reads must be combinational, regfile must write-through
// ======================================================================
`timescale 1ns/1ps

module processor #(
    parameter proc_pkg::word_t reset_pc = 32'd0
) (
    input  logic               clock,
    input  logic               rst_n,
    output proc_pkg::word_t    address_imem,
    input  proc_pkg::insn_t    q_imem,
    output proc_pkg::word_t    address_dmem,
    output proc_pkg::word_t    data,
    output logic               wren,
    input  proc_pkg::word_t    q_dmem,
    output logic               ctrl_write_enable,
    output proc_pkg::reg_idx_t ctrl_write_reg,
    output proc_pkg::reg_idx_t ctrl_read_reg_a,
    output proc_pkg::reg_idx_t ctrl_read_reg_b,
    output proc_pkg::word_t    data_write_reg,
    input  proc_pkg::word_t    data_read_reg_a,
    input  proc_pkg::word_t    data_read_reg_b
);
    import proc_pkg::*;

    word_t fd_pc;
    insn_t fd_ir;
    logic  redirect;
    word_t redirect_pc;
    logic  stall;
    insn_t dx_ir;
    insn_t xm_ir;
    word_t xm_alu_val;
    word_t xm_store_val;
    insn_t mw_ir;
    word_t wb_data;

    fetch_stage #(
        .reset_pc (reset_pc)
    ) fetch_i (
        .clock        (clock),
        .rst_n        (rst_n),
        .stall        (stall),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc),
        .q_imem       (q_imem),
        .address_imem (address_imem),
        .fd_pc        (fd_pc),
        .fd_ir        (fd_ir)
    );

    decode_stage decode_i (
        .fd_pc           (fd_pc),
        .fd_ir           (fd_ir),
        .data_read_reg_a (data_read_reg_a),
        .data_read_reg_b (data_read_reg_b),
        .xm_ir           (xm_ir),
        .xm_alu_val      (xm_alu_val),
        .mw_ir           (mw_ir),
        .wb_data         (wb_data),
        .ctrl_read_reg_a (ctrl_read_reg_a),
        .ctrl_read_reg_b (ctrl_read_reg_b),
        .redirect        (redirect),
        .redirect_pc     (redirect_pc)
    );

    hazard_unit hazard_i (
        .fd_ir (fd_ir),
        .dx_ir (dx_ir),
        .xm_ir (xm_ir),
        .stall (stall)
    );

    execute_stage execute_i (
        .clock           (clock),
        .rst_n           (rst_n),
        .stall           (stall),
        .fd_pc           (fd_pc),
        .fd_ir           (fd_ir),
        .data_read_reg_a (data_read_reg_a),
        .data_read_reg_b (data_read_reg_b),
        .mw_ir           (mw_ir),
        .wb_data         (wb_data),
        .dx_ir           (dx_ir),
        .xm_ir           (xm_ir),
        .xm_alu_val      (xm_alu_val),
        .xm_store_val    (xm_store_val)
    );

    mem_wb_stage mem_wb_i (
        .clock             (clock),
        .rst_n             (rst_n),
        .xm_ir             (xm_ir),
        .xm_alu_val        (xm_alu_val),
        .xm_store_val      (xm_store_val),
        .q_dmem            (q_dmem),
        .address_dmem      (address_dmem),
        .data              (data),
        .wren              (wren),
        .mw_ir             (mw_ir),
        .wb_data           (wb_data),
        .ctrl_write_enable (ctrl_write_enable),
        .ctrl_write_reg    (ctrl_write_reg),
        .data_write_reg    (data_write_reg)
    );

endmodule

// File: logic/mem_wb_stage.sv
// ======================================================================
// data memory drive, WM store-data bypass, M/W register, writeback
// dmem read is combinational, write happens on the clock edge
// ======================================================================
`timescale 1ns/1ps

module mem_wb_stage (
    input  logic               clock,
    input  logic               rst_n,
    input  proc_pkg::insn_t    xm_ir,
    input  proc_pkg::word_t    xm_alu_val,
    input  proc_pkg::word_t    xm_store_val,
    input  proc_pkg::word_t    q_dmem,
    output proc_pkg::word_t    address_dmem,
    output proc_pkg::word_t    data,
    output logic               wren,
    output proc_pkg::insn_t    mw_ir,
    output proc_pkg::word_t    wb_data,
    output logic               ctrl_write_enable,
    output proc_pkg::reg_idx_t ctrl_write_reg,
    output proc_pkg::word_t    data_write_reg
);
    import proc_pkg::*;

    word_t mw_alu_val;  // alu result or jal link
    word_t mw_load_val; // dmem read data
    logic  wm_hit;      // M/W writes the register sw stores

    assign address_dmem = xm_alu_val;               // rs + imm
    assign wren         = (opcode(xm_ir) == op_sw);
    assign wm_hit       = writes_rd(mw_ir) && rd(xm_ir) != 5'd0 && rd(mw_ir) == rd(xm_ir);
    assign data         = wm_hit ? wb_data : xm_store_val;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            mw_ir       <= nop_insn;
            mw_alu_val  <= '0;
            mw_load_val <= '0;
        end else begin
            mw_ir       <= xm_ir;
            mw_alu_val  <= xm_alu_val;
            mw_load_val <= q_dmem;
        end
    end

    assign wb_data           = (opcode(mw_ir) == op_lw) ? mw_load_val : mw_alu_val;
    assign ctrl_write_enable = writes_rd(mw_ir) && rd(mw_ir) != 5'd0; // r0 stays zero
    assign ctrl_write_reg    = rd(mw_ir);
    assign data_write_reg    = wb_data;

endmodule

// File: logic/execute_stage.sv
// ======================================================================
// D/X register, MX/WX operand bypass, ALU and X/M register
// jal leaves here as an r-type write of r31 carrying pc+1
// ======================================================================
`timescale 1ns/1ps

module execute_stage (
    input  logic            clock,
    input  logic            rst_n,
    input  logic            stall,
    input  proc_pkg::word_t fd_pc,
    input  proc_pkg::insn_t fd_ir,
    input  proc_pkg::word_t data_read_reg_a,
    input  proc_pkg::word_t data_read_reg_b,
    input  proc_pkg::insn_t mw_ir,
    input  proc_pkg::word_t wb_data,
    output proc_pkg::insn_t dx_ir,
    output proc_pkg::insn_t xm_ir,
    output proc_pkg::word_t xm_alu_val,
    output proc_pkg::word_t xm_store_val
);
    import proc_pkg::*;

    word_t      dx_pc;     // pc+1 of the insn in execute
    word_t      dx_a;      // rs value from regfile
    word_t      dx_b;      // rt or rd value from regfile
    opcode_e    dx_op;
    reg_idx_t   src_b;
    word_t      op_a;
    word_t      op_b_fwd;  // bypassed rt/rd, also store data
    word_t      op_b;
    alu_op_e    alu_op;
    logic [4:0] alu_shamt;
    word_t      alu_res;
    word_t      xm_val_in;
    insn_t      xm_ir_in;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            dx_ir <= nop_insn;
            dx_pc <= '0;
            dx_a  <= '0;
            dx_b  <= '0;
        end else begin
            dx_ir <= stall ? nop_insn : fd_ir; // bubble while decode holds
            dx_pc <= fd_pc;
            dx_a  <= data_read_reg_a;
            dx_b  <= data_read_reg_b;
        end
    end

    assign dx_op = opcode(dx_ir);
    assign src_b = (dx_op == op_alu) ? rt(dx_ir) : rd(dx_ir); // sw stores rd

    // MX beats WX, r0 excluded inside bypass_val
    assign op_a     = bypass_val(rs(dx_ir), dx_a, xm_ir, xm_alu_val, mw_ir, wb_data);
    assign op_b_fwd = bypass_val(src_b, dx_b, xm_ir, xm_alu_val, mw_ir, wb_data);

    assign op_b      = (dx_op inside {op_addi, op_lw, op_sw}) ? imm(dx_ir) : op_b_fwd;
    assign alu_op    = (dx_op == op_alu) ? alu_func(dx_ir) : alu_add; // addr calc adds
    assign alu_shamt = shamt(dx_ir);

    alu alu_i (
        .operand_a (op_a),
        .operand_b (op_b),
        .op        (alu_op),
        .shamt     (alu_shamt),
        .result    (alu_res)
    );

    always_comb begin
        if (dx_op == op_jal) begin
            xm_val_in = dx_pc;                          // link value
            xm_ir_in  = {op_alu, link_reg, dx_ir[21:0]}; // looks like an alu write
        end else begin
            xm_val_in = alu_res;
            xm_ir_in  = dx_ir;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            xm_ir        <= nop_insn;
            xm_alu_val   <= '0;
            xm_store_val <= '0;
        end else begin
            xm_ir        <= xm_ir_in;
            xm_alu_val   <= xm_val_in;
            xm_store_val <= op_b_fwd;
        end
    end

endmodule

// File: logic/hazard_unit.sv
// ======================================================================
// stall decision, combinational
// load-use into execute, and branch/jr operands not yet bypassable
// ======================================================================
`timescale 1ns/1ps

module hazard_unit (
    input  proc_pkg::insn_t fd_ir,
    input  proc_pkg::insn_t dx_ir,
    input  proc_pkg::insn_t xm_ir,
    output logic            stall
);
    import proc_pkg::*;

    // producer rd matches a comparator operand of the branch in decode
    function automatic logic feeds_branch(insn_t prod, insn_t cons);
        reg_idx_t dst;
        logic     uses_rd;
        logic     uses_rs;
        dst     = rd(prod);
        uses_rd = opcode(cons) inside {op_bne, op_blt, op_jr};
        uses_rs = opcode(cons) inside {op_bne, op_blt}; // jr reads rd only
        return (dst != 5'd0) &&
               ((uses_rd && dst == rd(cons)) || (uses_rs && dst == rs(cons)));
    endfunction

    logic load_use; // lw in D/X, consumer in decode
    logic br_dx;    // any result still in D/X
    logic br_xm;    // load data not there until M/W

    always_comb begin
        load_use = 1'b0;
        if (opcode(dx_ir) == op_lw && rd(dx_ir) != 5'd0) begin
            if (opcode(fd_ir) inside {op_alu, op_addi, op_lw, op_sw} &&
                rd(dx_ir) == rs(fd_ir))
                load_use = 1'b1; // base or first operand
            if (opcode(fd_ir) == op_alu && rd(dx_ir) == rt(fd_ir))
                load_use = 1'b1; // second r-type operand
        end
        br_dx = writes_rd(dx_ir) && feeds_branch(dx_ir, fd_ir);
        br_xm = (opcode(xm_ir) == op_lw) && feeds_branch(xm_ir, fd_ir);
        stall = load_use | br_dx | br_xm;
    end

endmodule

// File: logic/decode_stage.sv
// ======================================================================
// register read addressing and branch resolution in decode
// comparator operands bypassed from X/M and M/W, one-slot flush
// redirect is only meaningful when the hazard unit is not stalling
// ======================================================================
`timescale 1ns/1ps

module decode_stage (
    input  proc_pkg::word_t    fd_pc,
    input  proc_pkg::insn_t    fd_ir,
    input  proc_pkg::word_t    data_read_reg_a,
    input  proc_pkg::word_t    data_read_reg_b,
    input  proc_pkg::insn_t    xm_ir,
    input  proc_pkg::word_t    xm_alu_val,
    input  proc_pkg::insn_t    mw_ir,
    input  proc_pkg::word_t    wb_data,
    output proc_pkg::reg_idx_t ctrl_read_reg_a,
    output proc_pkg::reg_idx_t ctrl_read_reg_b,
    output logic               redirect,
    output proc_pkg::word_t    redirect_pc
);
    import proc_pkg::*;

    opcode_e fd_op;
    word_t   rd_val;    // branch lhs, also jr target
    word_t   rs_val;    // branch rhs
    word_t   br_target; // pc+1 + imm
    logic    rd_ne_rs;
    logic    rd_lt_rs;

    assign fd_op = opcode(fd_ir);

    // port b carries rt for r-type, rd for everything else
    assign ctrl_read_reg_a = rs(fd_ir);
    assign ctrl_read_reg_b = (fd_op == op_alu) ? rt(fd_ir) : rd(fd_ir);

    // MD then WD bypass into the comparator
    assign rd_val = bypass_val(rd(fd_ir), data_read_reg_b, xm_ir, xm_alu_val,
                               mw_ir, wb_data);
    assign rs_val = bypass_val(rs(fd_ir), data_read_reg_a, xm_ir, xm_alu_val,
                               mw_ir, wb_data);

    assign rd_ne_rs  = (rd_val != rs_val);
    assign rd_lt_rs  = ($signed(rd_val) < $signed(rs_val)); // signed compare
    assign br_target = fd_pc + imm(fd_ir);

    always_comb begin
        redirect    = 1'b0;
        redirect_pc = br_target;
        case (fd_op)
            op_j, op_jal: begin
                redirect    = 1'b1;
                redirect_pc = target(fd_ir); // absolute
            end
            op_jr: begin
                redirect    = 1'b1;
                redirect_pc = rd_val;
            end
            op_bne:  redirect = rd_ne_rs;
            op_blt:  redirect = rd_lt_rs;
            default: redirect = 1'b0;
        endcase
    end

endmodule

// File: logic/fetch_stage.sv
// ======================================================================
// PC register and F/D pipeline register
// stall holds both and beats a redirect, redirect flushes F/D
// ======================================================================
`timescale 1ns/1ps

module fetch_stage #(
    parameter proc_pkg::word_t reset_pc = 32'd0
) (
    input  logic            clock,
    input  logic            rst_n,
    input  logic            stall,
    input  logic            redirect,
    input  proc_pkg::word_t redirect_pc,
    input  proc_pkg::insn_t q_imem,
    output proc_pkg::word_t address_imem,
    output proc_pkg::word_t fd_pc,
    output proc_pkg::insn_t fd_ir
);
    import proc_pkg::*;

    word_t pc_q;   // address of insn being fetched
    word_t seq_pc; // pc + 1, word addressed

    assign seq_pc       = pc_q + 32'd1;
    assign address_imem = pc_q;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            pc_q <= reset_pc;
        end else if (!stall) begin
            pc_q <= redirect ? redirect_pc : seq_pc;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            fd_pc <= '0;
            fd_ir <= nop_insn;
        end else if (!stall) begin
            fd_pc <= seq_pc;                          // link value for jal
            fd_ir <= redirect ? nop_insn : q_imem;    // squash wrong-path slot
        end
    end

endmodule

// File: logic/alu.sv
// ======================================================================
// combinational ALU, add and sub wrap silently
// shifts act on operand_a by shamt, unknown ops give zero
// ======================================================================
`timescale 1ns/1ps

module alu (
    input  proc_pkg::word_t   operand_a,
    input  proc_pkg::word_t   operand_b,
    input  proc_pkg::alu_op_e op,
    input  logic [4:0]        shamt,
    output proc_pkg::word_t   result
);
    import proc_pkg::*;

    always_comb begin
        case (op)
            alu_add: result = operand_a + operand_b; // wraps
            alu_sub: result = operand_a - operand_b;
            alu_and: result = operand_a & operand_b;
            alu_or:  result = operand_a | operand_b;
            alu_sll: result = operand_a << shamt;    // logical left
            alu_sra: result = word_t'($signed(operand_a) >>> shamt); // keeps sign
            default: result = '0;
        endcase
    end

endmodule

// File: logic/proc_pkg.sv
// ======================================================================
// ISA definitions for the 32-bit word-addressed DLX-like core
// fixed widths throughout, opcode in bits 31..27, no overflow traps
// ======================================================================
package proc_pkg;

    typedef logic [31:0] word_t;    // data or word address
    typedef logic [31:0] insn_t;    // encoded instruction
    typedef logic [4:0]  reg_idx_t; // register index

    typedef enum logic [4:0] {
        op_alu  = 5'd0,             // r-type, function in bits 6..2
        op_j    = 5'd1,
        op_bne  = 5'd2,
        op_jal  = 5'd3,
        op_jr   = 5'd4,
        op_addi = 5'd5,
        op_blt  = 5'd6,
        op_sw   = 5'd7,
        op_lw   = 5'd8
    } opcode_e;

    typedef enum logic [4:0] {
        alu_add = 5'd0,
        alu_sub = 5'd1,
        alu_and = 5'd2,
        alu_or  = 5'd3,
        alu_sll = 5'd4,
        alu_sra = 5'd5
    } alu_op_e;

    localparam insn_t    nop_insn = 32'd0; // add r0, r0, r0
    localparam reg_idx_t link_reg = 5'd31; // jal destination

    function automatic opcode_e opcode(insn_t insn);
        return opcode_e'(insn[31:27]);
    endfunction

    function automatic alu_op_e alu_func(insn_t insn);
        return alu_op_e'(insn[6:2]);
    endfunction

    function automatic reg_idx_t rd(insn_t insn);
        return insn[26:22];
    endfunction

    function automatic reg_idx_t rs(insn_t insn);
        return insn[21:17];
    endfunction

    function automatic reg_idx_t rt(insn_t insn);
        return insn[16:12];
    endfunction

    function automatic logic [4:0] shamt(insn_t insn);
        return insn[11:7];
    endfunction

    function automatic word_t imm(insn_t insn);
        return {{15{insn[16]}}, insn[16:0]}; // sign-extend 17b
    endfunction

    function automatic word_t target(insn_t insn);
        return {5'd0, insn[26:0]}; // zero-extend 27b
    endfunction

    // results that reach the register file
    function automatic logic writes_rd(insn_t insn);
        return opcode(insn) inside {op_alu, op_addi, op_lw};
    endfunction

    // results already valid in X/M, so bypassable from there
    function automatic logic forwards_alu(insn_t insn);
        return opcode(insn) inside {op_alu, op_addi};
    endfunction

    // priority X/M then M/W then register file; r0 never bypassed
    function automatic word_t bypass_val(reg_idx_t src, word_t raw,
                                         insn_t xm_insn, word_t xm_val,
                                         insn_t mw_insn, word_t mw_val);
        if (src == 5'd0)
            return raw;
        if (forwards_alu(xm_insn) && rd(xm_insn) == src)
            return xm_val;
        if (writes_rd(mw_insn) && rd(mw_insn) == src)
            return mw_val;
        return raw;
    endfunction

endpackage
